/* tb/spriteTestdata.hex */
// sprite layer testdata, 32-bit words.
// sprites 0-63: X, pattern, attribute, Y byte (high to low).
// then ROM words 0-63, then checkpoints as line (3 digits), x (3 digits), colour (2 digits).
// plain, flip H, flip V, disabled, off line, X high, overlap pair
20000118 40001218 60002318 80008418 A0000460 F8004518 C0000618 C8010718
000000F0 000000F0 000000F0 000000F0 000000F0 000000F0 000000F0 000000F0
000000F0 000000F0 000000F0 000000F0 000000F0 000000F0 000000F0 000000F0
000000F0 000000F0 000000F0 000000F0 000000F0 000000F0 000000F0 000000F0
000000F0 000000F0 000000F0 000000F0 000000F0 000000F0 000000F0 000000F0
000000F0 000000F0 000000F0 000000F0 000000F0 000000F0 000000F0 000000F0
000000F0 000000F0 000000F0 000000F0 000000F0 000000F0 000000F0 000000F0
000000F0 000000F0 000000F0 000000F0 000000F0 000000F0 000000F0 000000F0
// pattern 0, pixel is column plus row
67452301 78563412 89674523 9A785634 AB896745 BC9A7856 CDAB8967 DEBC9A78
EFCDAB89 F0DEBC9A 01EFCDAB 12F0DEBC 2301EFCD 3412F0DE 452301EF 563412F0
EFCDAB89 F0DEBC9A 01EFCDAB 12F0DEBC 2301EFCD 3412F0DE 452301EF 563412F0
67452301 78563412 89674523 9A785634 AB896745 BC9A7856 CDAB8967 DEBC9A78
// pattern 1, odd columns opaque
0A0A0A0A 0A0A0A0A 0A0A0A0A 0A0A0A0A 0A0A0A0A 0A0A0A0A 0A0A0A0A 0A0A0A0A
0A0A0A0A 0A0A0A0A 0A0A0A0A 0A0A0A0A 0A0A0A0A 0A0A0A0A 0A0A0A0A 0A0A0A0A
0A0A0A0A 0A0A0A0A 0A0A0A0A 0A0A0A0A 0A0A0A0A 0A0A0A0A 0A0A0A0A 0A0A0A0A
0A0A0A0A 0A0A0A0A 0A0A0A0A 0A0A0A0A 0A0A0A0A 0A0A0A0A 0A0A0A0A 0A0A0A0A
// checkpoints: plain, flip H, flip V, disabled and off line, X high, overlap, empty lines
02002018 02002800 02702F1E 02302500 02004027 02004F28 02404328 02004700
02006037 02706535 02206B00 02108100 02508A00 0230A300 0201F858 02000353
0260075D 0261FF55 0200C46C 0200C97A 0200CA62 0200C800 0210D200 0210D37A
0210CE67 02802000 0281F800 0290C900 02A04500

/* sim.f */
common/spritePkg.sv
common/lineWriteIf.sv
hw/lineBuffer/dualPortRam.sv
hw/lineBuffer/lineDoubleBuffer.sv
hw/spriteEngine/spriteEngine.sv
hw/spriteLayer.sv
tb/tbMemModels.sv
tb/tbSpriteLayer.sv

/* Bender.yml */
package:
  name: spriteLayer

sources:
  - files:
      - common/spritePkg.sv
      - common/lineWriteIf.sv
      - hw/lineBuffer/dualPortRam.sv
      - hw/lineBuffer/lineDoubleBuffer.sv
      - hw/spriteEngine/spriteEngine.sv
      - hw/spriteLayer.sv
  - target: test
    files:
      - tb/tbMemModels.sv
      - tb/tbSpriteLayer.sv

/* tb/tbSpriteLayer.sv */
// testbench top: clock, reset, testdata loading, raster scan and output checks
`timescale 1ns/1ps

module tbSpriteLayer import spritePkg::*; ();

	localparam int firstLine  = 30;
	localparam int numLines   = 13;
	// the banks shown on the first two lines still hold the RAM's power-up contents.
	localparam int checkFrom  = firstLine + 2;
	localparam int chrWords   = 64;
	localparam int numChecks  = 48;
	localparam int fileDepth  = numSprites + chrWords + numChecks;
	localparam int randomLine = 40;

	logic    VCLK;
	logic    arstN;
	hPos     ph;
	vPos     pv;
	attrAddr attrRdAddr;
	attrByte attrRdData;
	chrAddr  chrRdAddr;
	chrWord  chrRdData;
	logic    chrSlot;
	pixColor spriteColor;

	logic [31:0] fileWords [0:fileDepth-1];
	logic [15:0] lfsrState;
	// checkpoint colours by line offset and x.
	pixColor     cpColor [0:numLines*512-1];
	logic        cpValid [0:numLines*512-1];

	initial VCLK = 1'b0;
	always #5 VCLK = ~VCLK;

	spriteLayer dut (
		.VCLK        (VCLK),
		.arstN       (arstN),
		.ph          (ph),
		.pv          (pv),
		.attrRdAddr  (attrRdAddr),
		.attrRdData  (attrRdData),
		.chrRdAddr   (chrRdAddr),
		.chrRdData   (chrRdData),
		.chrSlot     (chrSlot),
		.spriteColor (spriteColor)
	);

	attrMemModel attrMem (
		.VCLK   (VCLK),
		.rdAddr (attrRdAddr),
		.rdData (attrRdData)
	);

	chrRomModel chrRom (
		.VCLK   (VCLK),
		.rdAddr (chrRdAddr),
		.rdData (chrRdData),
		.slot   (chrSlot)
	);

	// taps 16, 14, 13 and 11.
	function automatic logic [15:0] lfsrNext(input logic [15:0] s);
		logic fb;
		fb = s[15] ^ s[13] ^ s[12] ^ s[10];
		return {s[14:0], fb};
	endfunction

	task automatic randomBits(input int n, output int v);
		v = 0;
		for (int i = 0; i < n; i++) begin
			lfsrState = lfsrNext(lfsrState);
			v = (v << 1) | lfsrState[0];
		end
	endtask

	// colour of one screen pixel, later sprites painted over earlier ones.
	function automatic pixColor refColor(input int line, input int x);
		pixColor     c;
		int          row;
		int          d;
		int          col;
		int          xs;
		logic [31:0] w;
		logic [3:0]  pix;
		logic [7:0]  y;
		logic [7:0]  a;
		logic [7:0]  p;
		c = '0;
		for (int n = 0; n < numSprites; n++) begin
			y   = fileWords[n][7:0];
			a   = fileWords[n][15:8];
			p   = fileWords[n][23:16];
			xs  = {a[attrXHigh], fileWords[n][31:24]};
			row = (line - y) & 511;
			d   = (x - xs) & 511;
			if (row < spriteHeight && d < spriteWidth && !a[attrDisable]) begin
				col = a[attrFlipH] ? spriteWidth - 1 - d : d;
				if (a[attrFlipV])
					row = spriteHeight - 1 - row;
				w   = chrRom.mem[p * 32 + (row / 8) * 16 + (col / 8) * 8 + row % 8];
				pix = w[(col % 8) / 2 * 8 + ((col % 2 == 0) ? 4 : 0) +: 4];
				if (pix != 0)
					c = {a[3:0], pix};
			end
		end
		return c;
	endfunction

	task automatic checkEqual(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected) begin
			$display("ERROR at %0t ns: %s expected %0h, actual %0h",
				$time, name, expected, actual);
			$display("SIMULATION FAILED");
			$fatal(1, "value mismatch on %s", name);
		end
	endtask

	// the attribute address has three zero bits between sprite number and byte index.
	always @(negedge VCLK) begin
		if (arstN)
			checkEqual("attrRdAddr[4:2]", attrRdAddr[4:2], 32'd0);
	end

	initial begin
		logic [31:0] w;
		int          idx;
		int          cpLine;
		int          cpX;
		arstN     = 1'b0;
		// ph starts at the end of a line so that the first line begins with a change to 0.
		ph        = '1;
		pv        = vPos'(firstLine);
		lfsrState = 16'd57158;
		for (int i = 0; i < fileDepth; i++)
			fileWords[i] = '1;
		$readmemh("tb/spriteTestdata.hex", fileWords);
		if (fileWords[0] === '1) begin
			$display("the testdata file could not be read");
			$display("SIMULATION FAILED");
			$fatal(1, "no testdata");
		end
		for (int i = 0; i < numSprites * 4; i++)
			attrMem.mem[i] = fileWords[i / 4][(i % 4) * 8 +: 8];
		for (int i = 0; i < chrWords; i++)
			chrRom.mem[i] = fileWords[numSprites + i];
		for (int i = 0; i < numLines * 512; i++) begin
			cpValid[i] = 1'b0;
			cpColor[i] = '0;
		end
		// unused checkpoint slots become random points on the empty line.
		for (int i = 0; i < numChecks; i++) begin
			w = fileWords[numSprites + chrWords + i];
			if (w[31:20] == 12'hFFF) begin
				randomBits(9, cpX);
				cpLine = randomLine;
			end else begin
				cpLine = w[31:20];
				cpX    = w[19:8];
			end
			idx = (cpLine - firstLine) * 512 + cpX;
			if (!cpValid[idx]) begin
				cpValid[idx] = 1'b1;
				cpColor[idx] = (w[31:20] == 12'hFFF) ? 8'h00 : w[7:0];
			end
		end

		repeat (3) @(negedge VCLK);
		arstN = 1'b1;

		for (int ln = 0; ln < numLines; ln++) begin
			for (int x = 0; x < 512; x++) begin
				@(negedge VCLK);
				pv = vPos'(firstLine + ln);
				ph = hPos'(x);
				repeat (3) @(negedge VCLK);
				if (firstLine + ln >= checkFrom) begin
					idx = ln * 512 + x;
					checkEqual($sformatf("spriteColor line %0d x %0d", firstLine + ln, x),
						spriteColor, refColor(firstLine + ln, x));
					if (cpValid[idx])
						checkEqual($sformatf("spriteColor checkpoint line %0d x %0d",
							firstLine + ln, x), spriteColor, cpColor[idx]);
				end
			end
		end
		$display("SIMULATION PASSED");
		$finish;
	end

	initial begin
		#((numLines * 512 * 4 + 500) * 10);
		$display("timeout: the raster scan did not finish in time");
		$display("SIMULATION FAILED");
		$fatal(1, "watchdog expired");
	end

endmodule

/* tb/tbMemModels.sv */
// attribute memory model and character ROM model with the fetch-slot strobe generator
`timescale 1ns/1ps

module attrMemModel import spritePkg::*; (
	input  logic    VCLK,
	input  attrAddr rdAddr,
	output attrByte rdData
);

	// four bytes per sprite, indexed by sprite number and byte index.
	attrByte mem [0:numSprites*4-1];
	attrAddr addrReg;

	initial begin
		rdData  = '0;
		addrReg = '0;
	end

	always @(posedge VCLK)
		addrReg <= rdAddr;

	// the byte for the previous cycle's address goes out on the falling edge.
	always @(negedge VCLK)
		rdData <= mem[{addrReg[10:5], addrReg[1:0]}];

endmodule

module chrRomModel import spritePkg::*; (
	input  logic   VCLK,
	input  chrAddr rdAddr,
	output chrWord rdData,
	output logic   slot
);

	chrWord mem [0:8191];

	initial begin
		rdData = '0;
		slot   = 1'b0;
	end

	// a fetch slot every other cycle, with the word for the address held in that cycle.
	always @(negedge VCLK) begin
		slot   <= ~slot;
		rdData <= mem[rdAddr];
	end

endmodule

/* hw/spriteLayer.sv */
// sprite layer top level joining the sprite engine and the line double buffer
`timescale 1ns/1ps

module spriteLayer import spritePkg::*; (
	input  logic    VCLK,
	input  logic    arstN,
	input  hPos     ph,
	input  vPos     pv,

	// attribute memory, data one cycle after the address.
	output attrAddr attrRdAddr,
	input  attrByte attrRdData,

	// character ROM, data valid in the fetch slot.
	output chrAddr  chrRdAddr,
	input  chrWord  chrRdData,
	input  logic    chrSlot,

	output pixColor spriteColor
);

	lineWriteIf lineWrBus ();

	spriteEngine engine (
		.VCLK       (VCLK),
		.arstN      (arstN),
		.ph         (ph),
		.pv         (pv),
		.attrRdAddr (attrRdAddr),
		.attrRdData (attrRdData),
		.chrRdAddr  (chrRdAddr),
		.chrRdData  (chrRdData),
		.chrSlot    (chrSlot),
		.lineWr     (lineWrBus.engine)
	);

	lineDoubleBuffer lineBuf (
		.VCLK        (VCLK),
		.arstN       (arstN),
		.ph          (ph),
		.pv          (pv),
		.lineWr      (lineWrBus.buffer),
		.spriteColor (spriteColor)
	);

endmodule

/* hw/spriteEngine/spriteEngine.sv */
// sprite engine: per-line table walk, hit test, character fetch and pixel writer
`timescale 1ns/1ps

module spriteEngine import spritePkg::*; (
	input  logic       VCLK,
	input  logic       arstN,
	input  hPos        ph,
	input  vPos        pv,
	output attrAddr    attrRdAddr,
	input  attrByte    attrRdData,
	output chrAddr     chrRdAddr,
	input  chrWord     chrRdData,
	input  logic       chrSlot,
	lineWriteIf.engine lineWr
);

	engineState state;
	hPos        phPrev;
	spriteIdx   sprNo;
	spriteIdx   addrSprite;
	logic [1:0] byteIdx;
	logic       chrHalf;
	logic [3:0] col;

	vPos        targetLine;
	attrByte    yReg;
	attrByte    attrReg;
	attrByte    patReg;
	attrByte    xReg;
	logic [3:0] rowReg;
	chrWord     chrWord0;
	chrWord     chrWord1;

	logic       lineStart;
	vPos        rowDiff;
	logic       yHit;
	logic [3:0] chrRow;
	logic [3:0] colOffs;
	chrWord     drawWord;
	logic [3:0] pixIdx;
	hPos        pixX;

	assign lineStart = (ph == '0) && (phPrev != '0);

	// the row within the sprite is only valid while the attribute byte is on the bus.
	assign rowDiff = targetLine - vPos'(yReg);
	assign yHit    = (rowDiff < vPos'(spriteHeight)) && !attrRdData[attrDisable];

	// memory data lags the address by one cycle, so each state already
	// addresses the byte that the following state consumes.
	always_comb begin
		addrSprite = sprNo;
		case (state)
			idle:       byteIdx = byteY;
			readY:      byteIdx = byteAttr;
			readAttr:   byteIdx = bytePattern;
			nextSprite: begin
				byteIdx    = byteY;
				addrSprite = spriteIdx'(sprNo + 1'b1);
			end
			default:    byteIdx = byteX;
		endcase
	end

	assign attrRdAddr = {addrSprite, 3'b000, byteIdx};

	assign chrRow    = rowReg ^ {4{attrReg[attrFlipV]}};
	assign chrRdAddr = {patReg, chrRow[3], chrHalf, chrRow[2:0]};

	// pixels run byte by byte from the low byte, high nibble first.
	assign drawWord = col[3] ? chrWord1 : chrWord0;
	assign pixIdx   = drawWord[{col[2:1], ~col[0], 2'b00} +: 4];
	assign colOffs  = col ^ {4{attrReg[attrFlipH]}};
	assign pixX     = {attrReg[attrXHigh], xReg} + hPos'(colOffs);

	assign lineWr.wrEn    = (state == draw) && (pixIdx != 4'd0);
	assign lineWr.wrAddr  = {~lineWr.lineBank, pixX};
	assign lineWr.wrPixel = {attrReg[3:0], pixIdx};

	always_ff @(posedge VCLK or negedge arstN) begin
		if (!arstN) begin
			state   <= idle;
			phPrev  <= '0;
			sprNo   <= '0;
			chrHalf <= 1'b0;
			col     <= '0;
		end else begin
			phPrev <= ph;
			case (state)
				idle: begin
					if (lineStart) begin
						sprNo <= '0;
						state <= readY;
					end
				end
				readY:       state <= readAttr;
				readAttr:    state <= yHit ? readPattern : nextSprite;
				readPattern: state <= readX;
				readX: begin
					if (chrSlot) begin
						chrHalf <= 1'b0;
						state   <= fetchChr;
					end
				end
				fetchChr: begin
					if (chrSlot) begin
						chrHalf <= 1'b1;
						if (chrHalf) begin
							col   <= '0;
							state <= draw;
						end
					end
				end
				draw: begin
					col <= col + 1'b1;
					if (col == 4'(spriteWidth - 1))
						state <= nextSprite;
				end
				nextSprite: begin
					sprNo <= addrSprite;
					state <= (sprNo == spriteIdx'(numSprites - 1)) ? idle : readY;
				end
				default: state <= idle;
			endcase
		end
	end

	always_ff @(posedge VCLK) begin
		case (state)
			idle: begin
				if (lineStart)
					targetLine <= vPos'(pv + 1'b1);
			end
			readY: yReg <= attrRdData;
			readAttr: begin
				attrReg <= attrRdData;
				rowReg  <= rowDiff[3:0];
			end
			readPattern: patReg <= attrRdData;
			readX: begin
				if (chrSlot)
					xReg <= attrRdData;
			end
			fetchChr: begin
				if (chrSlot) begin
					if (chrHalf)
						chrWord1 <= chrRdData;
					else
						chrWord0 <= chrRdData;
				end
			end
			default: ;
		endcase
	end

endmodule

/* hw/lineBuffer/lineDoubleBuffer.sv */
// two-bank line buffer with bank select, read-and-clear readout and output register
`timescale 1ns/1ps

module lineDoubleBuffer import spritePkg::*; (
	input  logic       VCLK,
	input  logic       arstN,
	input  hPos        ph,
	input  vPos        pv,
	lineWriteIf.buffer lineWr,
	output pixColor    spriteColor
);

	hPos     phPrev;
	logic    phChange;
	logic    lineBank;
	logic    frontBank;
	logic    clrPend;
	bufAddr  clrAddr;
	bufAddr  rwAddr;
	logic    rwEn;
	logic    rwWrite;
	pixColor rdData;

	assign phChange = (ph != phPrev);

	// the first read of a line already uses the bank of the new line.
	assign frontBank = (phChange && (ph == '0)) ? pv[0] : lineBank;

	// a read on a change of ph, and the clear of that location one cycle later.
	assign rwEn    = phChange || clrPend;
	assign rwWrite = !phChange;
	assign rwAddr  = phChange ? {frontBank, ph} : clrAddr;

	assign lineWr.lineBank = lineBank;

	always_ff @(posedge VCLK or negedge arstN) begin
		if (!arstN) begin
			phPrev      <= '0;
			lineBank    <= 1'b0;
			clrPend     <= 1'b0;
			spriteColor <= '0;
		end else begin
			phPrev  <= ph;
			clrPend <= phChange;
			if (phChange && (ph == '0))
				lineBank <= pv[0];
			if (clrPend)
				spriteColor <= rdData;
		end
	end

	always_ff @(posedge VCLK) begin
		if (phChange)
			clrAddr <= {frontBank, ph};
	end

	dualPortRam ram (
		.VCLK    (VCLK),
		.rwAddr  (rwAddr),
		.rwEn    (rwEn),
		.rwWrite (rwWrite),
		.rwData  (pixColor'(0)),
		.rdData  (rdData),
		.wrAddr  (lineWr.wrAddr),
		.wrEn    (lineWr.wrEn),
		.wrData  (lineWr.wrPixel)
	);

endmodule

/* hw/lineBuffer/dualPortRam.sv */
// line buffer RAM with one registered read/write port and one write port
`timescale 1ns/1ps

module dualPortRam import spritePkg::*; (
	input  logic    VCLK,
	input  bufAddr  rwAddr,
	input  logic    rwEn,
	input  logic    rwWrite,
	input  pixColor rwData,
	output pixColor rdData,
	input  bufAddr  wrAddr,
	input  logic    wrEn,
	input  pixColor wrData
);

	pixColor mem [0:bufDepth-1];

	// both ports touch different banks in normal operation.
	always_ff @(posedge VCLK) begin
		if (rwEn) begin
			if (rwWrite)
				mem[rwAddr] <= rwData;
			else
				rdData <= mem[rwAddr];
		end
		if (wrEn)
			mem[wrAddr] <= wrData;
	end

endmodule

/* common/lineWriteIf.sv */
// line buffer write interface between the sprite engine and the double buffer
`timescale 1ns/1ps

interface lineWriteIf import spritePkg::*; ();

	logic    wrEn;
	bufAddr  wrAddr;
	pixColor wrPixel;
	// the engine draws into the bank that is not on screen.
	logic    lineBank;

	modport engine (
		output wrEn,
		output wrAddr,
		output wrPixel,
		input  lineBank
	);

	modport buffer (
		input  wrEn,
		input  wrAddr,
		input  wrPixel,
		output lineBank
	);

endinterface

/* common/spritePkg.sv */
// sprite layer package: table, pixel and buffer widths, engine states, attribute bits
package spritePkg;

	// sprite table geometry.
	localparam int numSprites   = 64;
	localparam int spriteHeight = 16;
	localparam int spriteWidth  = 16;

	// line buffer depth covers both banks of 512 pixels.
	localparam int bufDepth = 1024;

	// attribute byte layout; bits 3..0 hold the palette number.
	localparam int attrFlipH   = 4;
	localparam int attrFlipV   = 5;
	localparam int attrXHigh   = 6;
	localparam int attrDisable = 7;

	// byte order of one sprite entry in the attribute memory.
	localparam logic [1:0] byteY       = 2'd0;
	localparam logic [1:0] byteAttr    = 2'd1;
	localparam logic [1:0] bytePattern = 2'd2;
	localparam logic [1:0] byteX       = 2'd3;

	typedef logic [8:0]  hPos;
	typedef logic [8:0]  vPos;
	typedef logic [5:0]  spriteIdx;
	typedef logic [10:0] attrAddr;
	typedef logic [7:0]  attrByte;
	typedef logic [12:0] chrAddr;
	typedef logic [31:0] chrWord;
	typedef logic [7:0]  pixColor;
	typedef logic [9:0]  bufAddr;

	typedef enum logic [2:0] {
		idle,
		readY,
		readAttr,
		readPattern,
		readX,
		fetchChr,
		draw,
		nextSprite
	} engineState;

endpackage
